//--- hw/rv_types_pkg.sv
package rv_types_pkg;

  // ####################
  // Data widths
  // ####################

  localparam int xlen = 32;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      ecause_t;

  // ####################
  // Operation codes
  // ####################

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [1:0] {
    mul_mul,
    mul_mulh,
    mul_mulhsu,
    mul_mulhu
  } mul_op_t;

  typedef enum logic [1:0] {
    div_div,
    div_divu,
    div_rem,
    div_remu
  } div_op_t;

  typedef enum logic [2:0] {
    class_alu,
    class_lui,
    class_auipc,
    class_jump,    // JAL and JALR.
    class_mul,
    class_div,
    class_system   // ECALL, EBREAK, FENCE.
  } op_class_t;

  // Machine mode cause codes.
  localparam ecause_t except_illegal_instruction = 4'd2;
  localparam ecause_t except_breakpoint          = 4'd3;
  localparam ecause_t except_env_call_mach       = 4'd11;

  localparam int div_cycles = 32;  // One restoring step per bit.

endpackage

//--- hw/execute_pkg.sv
package execute_pkg;

  import rv_types_pkg::*;

  // ####################
  // Issue and results
  // ####################

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     instr;
    xlen_t     rdata1;
    xlen_t     rdata2;
    xlen_t     imm;
    reg_addr_t waddr;
    logic      sel_imm;    // Second operand from imm.
    op_class_t op_class;
    alu_op_t   alu_op;
    mul_op_t   mul_op;
    div_op_t   div_op;
    logic      ecall;
    logic      ebreak;
    logic      illegal;
  } issue_t;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    xlen_t     wdata;
  } writeback_t;

  typedef struct packed {
    logic    exception;
    ecause_t ecause;
    xlen_t   epc;
    xlen_t   etval;
  } trap_t;

  // ####################
  // Unit bundles
  // ####################

  typedef struct packed {
    xlen_t   rdata1;
    xlen_t   rdata2;
    xlen_t   imm;
    logic    sel_imm;
    alu_op_t alu_op;
  } alu_in_t;

  typedef struct packed {
    logic    enable;   // One cycle start strobe.
    xlen_t   rdata1;
    xlen_t   rdata2;
    mul_op_t op;
  } mul_in_t;

  typedef struct packed {
    logic    enable;
    xlen_t   rdata1;
    xlen_t   rdata2;
    div_op_t op;
  } div_in_t;

  typedef struct packed {
    logic  ready;      // One cycle with result.
    xlen_t result;
  } unit_out_t;

endpackage

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
  input  execute_pkg::alu_in_t in,
  output rv_types_pkg::xlen_t  result
);

  import rv_types_pkg::*;

  xlen_t      op_b;
  logic [4:0] shamt;

  always_comb begin
    op_b  = in.sel_imm ? in.imm : in.rdata2;
    shamt = op_b[4:0];  // Low five bits only.

    unique case (in.alu_op)
      alu_add: begin
        result = in.rdata1 + op_b;
      end
      alu_sub: begin
        result = in.rdata1 - op_b;
      end
      alu_sll: begin
        result = in.rdata1 << shamt;
      end
      alu_slt: begin
        result = {31'b0, $signed(in.rdata1) < $signed(op_b)};
      end
      alu_sltu: begin
        result = {31'b0, in.rdata1 < op_b};
      end
      alu_xor: begin
        result = in.rdata1 ^ op_b;
      end
      alu_srl: begin
        result = in.rdata1 >> shamt;
      end
      alu_sra: begin
        result = xlen_t'($signed(in.rdata1) >>> shamt);
      end
      alu_or: begin
        result = in.rdata1 | op_b;
      end
      alu_and: begin
        result = in.rdata1 & op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hw/multiplier.sv
`timescale 1ns/1ps

module multiplier (
  input  logic                   clock,
  input  logic                   reset,
  input  execute_pkg::mul_in_t   in,
  output execute_pkg::unit_out_t out
);

  import rv_types_pkg::*;

  logic               sign_a;
  logic               sign_b;
  logic signed [32:0] op_a;
  logic signed [32:0] op_b;
  logic signed [65:0] product;

  logic               valid_q;
  mul_op_t            op_q;
  logic        [65:0] product_q;
  logic               ready_q;
  xlen_t              result_q;

  always_comb begin
    sign_a  = (in.op == mul_mulh) || (in.op == mul_mulhsu);
    sign_b  = (in.op == mul_mulh);
    op_a    = {sign_a & in.rdata1[31], in.rdata1};
    op_b    = {sign_b & in.rdata2[31], in.rdata2};
    product = op_a * op_b;
  end

  // Stage one holds the full product.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in.enable;
    end
    op_q      <= in.op;
    product_q <= product;
  end

  // Stage two picks the word.
  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_q;
    end
    result_q <= (op_q == mul_mul) ? product_q[31:0] : product_q[63:32];
  end

  assign out.ready  = ready_q;
  assign out.result = result_q;

  a_ready_latency: assert property (@(posedge clock) disable iff (reset)
    out.ready == $past(in.enable, 2));

endmodule

//--- hw/divider.sv
`timescale 1ns/1ps

module divider (
  input  logic                   clock,
  input  logic                   reset,
  input  execute_pkg::div_in_t   in,
  input  logic                   abort,
  output execute_pkg::unit_out_t out
);

  import rv_types_pkg::*;

  typedef enum logic [1:0] {idle, run, done} div_state_t;

  div_state_t  state;
  logic [5:0]  count;
  div_op_t     op_q;
  xlen_t       dividend;
  xlen_t       divisor;
  xlen_t       quot;
  xlen_t       rem;
  logic        neg_quot;
  logic        neg_rem;
  logic        div_zero;
  logic        overflow;

  logic        op_signed;
  xlen_t       mag_a;
  xlen_t       mag_b;
  logic [32:0] rem_shift;
  logic [32:0] diff;
  logic        is_rem;
  xlen_t       quot_fix;
  xlen_t       rem_fix;

  always_comb begin
    op_signed = (in.op == div_div) || (in.op == div_rem);
    mag_a     = (op_signed && in.rdata1[31]) ? -in.rdata1 : in.rdata1;
    mag_b     = (op_signed && in.rdata2[31]) ? -in.rdata2 : in.rdata2;
    rem_shift = {rem, quot[31]};
    diff      = rem_shift - {1'b0, divisor};  // Borrow in bit 32.
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      count <= '0;
    end else if (abort) begin
      state <= idle;
    end else begin
      unique case (state)
        idle: begin
          if (in.enable) begin
            state    <= run;
            count    <= '0;
            op_q     <= in.op;
            dividend <= in.rdata1;
            divisor  <= mag_b;
            quot     <= mag_a;
            rem      <= '0;
            neg_quot <= op_signed & (in.rdata1[31] ^ in.rdata2[31]);
            neg_rem  <= op_signed & in.rdata1[31];
            div_zero <= (in.rdata2 == '0);
            overflow <= op_signed & (in.rdata1 == 32'h8000_0000) & (in.rdata2 == '1);
          end
        end
        run: begin
          rem  <= diff[32] ? rem_shift[31:0] : diff[31:0];
          quot <= {quot[30:0], ~diff[32]};
          count <= count + 6'd1;
          if (count == 6'(div_cycles - 1)) begin
            state <= done;
          end
        end
        default: begin
          state <= idle;  // Result seen for one cycle.
        end
      endcase
    end
  end

  always_comb begin
    is_rem   = (op_q == div_rem) || (op_q == div_remu);
    quot_fix = neg_quot ? -quot : quot;
    rem_fix  = neg_rem ? -rem : rem;
    if (div_zero) begin
      out.result = is_rem ? dividend : '1;
    end else if (overflow) begin
      out.result = is_rem ? '0 : dividend;
    end else begin
      out.result = is_rem ? rem_fix : quot_fix;
    end
    out.ready = (state == done);
  end

  a_enable_idle: assert property (@(posedge clock) disable iff (reset)
    in.enable |-> state == idle);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  execute_pkg::issue_t     issue,
  input  logic                    flush,
  output execute_pkg::alu_in_t    alu_in,
  input  rv_types_pkg::xlen_t     alu_result,
  output execute_pkg::mul_in_t    mul_in,
  input  execute_pkg::unit_out_t  mul_out,
  output execute_pkg::div_in_t    div_in,
  input  execute_pkg::unit_out_t  div_out,
  output logic                    div_abort,
  output execute_pkg::writeback_t wb,
  output execute_pkg::trap_t      trap,
  output logic                    stall,
  output logic                    retired
);

  import rv_types_pkg::*;
  import execute_pkg::*;

  typedef struct packed {
    issue_t instr;
    logic   started;  // Unit enable already sent.
  } stage_reg_t;

  stage_reg_t r;
  stage_reg_t rin;
  stage_reg_t v;

  logic  has_except;
  logic  is_mul;
  logic  is_div;
  logic  unit_ready;
  xlen_t wdata;

  always_comb begin
    v = r;

    // ####################
    // Unit steering
    // ####################

    has_except = r.instr.illegal | r.instr.ebreak | r.instr.ecall;
    is_mul     = r.instr.valid & ~has_except & (r.instr.op_class == class_mul);
    is_div     = r.instr.valid & ~has_except & (r.instr.op_class == class_div);
    unit_ready = (is_mul & mul_out.ready) | (is_div & div_out.ready);

    stall = (is_mul | is_div) & ~unit_ready & ~flush;  // Flush wins.

    alu_in.rdata1  = r.instr.rdata1;
    alu_in.rdata2  = r.instr.rdata2;
    alu_in.imm     = r.instr.imm;
    alu_in.sel_imm = r.instr.sel_imm;
    alu_in.alu_op  = r.instr.alu_op;

    mul_in.enable = is_mul & ~r.started & ~flush;
    mul_in.rdata1 = r.instr.rdata1;
    mul_in.rdata2 = r.instr.rdata2;
    mul_in.op     = r.instr.mul_op;

    div_in.enable = is_div & ~r.started & ~flush;
    div_in.rdata1 = r.instr.rdata1;
    div_in.rdata2 = r.instr.rdata2;
    div_in.op     = r.instr.div_op;

    div_abort = is_div & flush;

    // ####################
    // Write-back and traps
    // ####################

    case (r.instr.op_class)
      class_lui:   wdata = r.instr.imm;
      class_auipc: wdata = r.instr.pc + r.instr.imm;
      class_jump:  wdata = r.instr.pc + 32'd4;  // Link address.
      class_mul:   wdata = mul_out.result;
      class_div:   wdata = div_out.result;
      default:     wdata = alu_result;
    endcase

    wb.wren  = r.instr.valid & ~has_except & ~stall & ~flush &
               (r.instr.op_class != class_system) & (r.instr.waddr != '0);
    wb.waddr = r.instr.waddr;
    wb.wdata = wdata;

    trap.exception = r.instr.valid & has_except & ~flush;
    if (r.instr.illegal) begin
      trap.ecause = except_illegal_instruction;
    end else if (r.instr.ebreak) begin
      trap.ecause = except_breakpoint;
    end else if (r.instr.ecall) begin
      trap.ecause = except_env_call_mach;
    end else begin
      trap.ecause = '0;
    end
    trap.epc   = r.instr.pc;
    trap.etval = r.instr.instr;

    retired = r.instr.valid & ~stall & ~flush;

    // Next held instruction.
    if (flush) begin
      v.instr.valid = 1'b0;
      v.started     = 1'b0;
    end else if (!stall) begin
      v.instr   = issue;
      v.started = 1'b0;
    end else if (mul_in.enable | div_in.enable) begin
      v.started = 1'b1;
    end

    rin = v;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    wb.wren |-> wb.waddr != '0);

  // Strobe lasts one cycle per instruction.
  a_enable_once: assert property (@(posedge clock) disable iff (reset)
    (mul_in.enable | div_in.enable) |=> !(mul_in.enable | div_in.enable));

endmodule

//--- hw/execute_top.sv
`timescale 1ns/1ps

module execute_top (
  input  logic                    clock,
  input  logic                    reset,
  input  execute_pkg::issue_t     issue,
  input  logic                    flush,
  output execute_pkg::writeback_t wb,
  output execute_pkg::trap_t      trap,
  output logic                    stall,
  output logic                    retired
);

  import rv_types_pkg::*;
  import execute_pkg::*;

  alu_in_t   alu_in;
  xlen_t     alu_result;
  mul_in_t   mul_in;
  unit_out_t mul_out;
  div_in_t   div_in;
  unit_out_t div_out;
  logic      div_abort;

  execute_stage u_stage (
    .clock      (clock),
    .reset      (reset),
    .issue      (issue),
    .flush      (flush),
    .alu_in     (alu_in),
    .alu_result (alu_result),
    .mul_in     (mul_in),
    .mul_out    (mul_out),
    .div_in     (div_in),
    .div_out    (div_out),
    .div_abort  (div_abort),
    .wb         (wb),
    .trap       (trap),
    .stall      (stall),
    .retired    (retired)
  );

  alu u_alu (
    .in     (alu_in),
    .result (alu_result)
  );

  multiplier u_mul (
    .clock (clock),
    .reset (reset),
    .in    (mul_in),
    .out   (mul_out)
  );

  divider u_div (
    .clock (clock),
    .reset (reset),
    .in    (div_in),
    .abort (div_abort),
    .out   (div_out)
  );

endmodule

//--- dv/tb_execute.sv
`timescale 1ns/1ps

module tb_execute;

  import rv_types_pkg::*;
  import execute_pkg::*;

  localparam int reset_cycles = 16;
  localparam int random_tests = 24;
  localparam int unit_wait    = div_cycles + 8;

  typedef struct packed {
    issue_t issue;
    logic   flush;     // Flush the held divide.
    xlen_t  expected;  // Write data or cause code.
  } pattern_t;

  logic       clock;
  logic       reset;
  issue_t     issue;
  logic       flush;
  writeback_t wb;
  trap_t      trap;
  logic       stall;
  logic       retired;

  pattern_t   patterns[$];
  string      names[$];
  string      kinds[$];
  int         cycles = 0;
  int         cycle_limit = 100000;
  int         wb_errors = 0;
  int         trap_errors = 0;
  int         other_errors = 0;

  execute_top u_execute_top (
    .clock   (clock),
    .reset   (reset),
    .issue   (issue),
    .flush   (flush),
    .wb      (wb),
    .trap    (trap),
    .stall   (stall),
    .retired (retired)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Run stopped, no progress after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ####################
  // Reference rules
  // ####################

  function automatic xlen_t mul_expected(mul_op_t op, xlen_t a, xlen_t b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    ext_a = (op == mul_mulh || op == mul_mulhsu) ? {{32{a[31]}}, a} : {32'b0, a};
    ext_b = (op == mul_mulh) ? {{32{b[31]}}, b} : {32'b0, b};
    prod  = ext_a * ext_b;  // Low 64 bits are exact.
    return (op == mul_mul) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic xlen_t div_expected(div_op_t op, xlen_t a, xlen_t b);
    logic is_rem;
    is_rem = (op == div_rem) || (op == div_remu);
    if (b == '0) return is_rem ? a : 32'hffff_ffff;
    if ((op == div_div || op == div_rem) && a == 32'h8000_0000 && b == 32'hffff_ffff)
      return is_rem ? 32'h0 : a;
    case (op)
      div_div:  return xlen_t'($signed(a) / $signed(b));  // Rounds toward zero.
      div_rem:  return xlen_t'($signed(a) % $signed(b));
      div_divu: return a / b;
      default:  return a % b;
    endcase
  endfunction

  function automatic int expected_latency(op_class_t cls);
    case (cls)
      class_mul: return 3;  // Enable, then two stages.
      class_div: return div_cycles + 2;
      default:   return 1;
    endcase
  endfunction

  // ####################
  // Checks
  // ####################

  task automatic check_wb(string test, writeback_t exp, writeback_t act, logic data_known);
    if (act.wren !== exp.wren ||
        (data_known && (act.waddr !== exp.waddr || act.wdata !== exp.wdata))) begin
      wb_errors++;
      $display("ERR %s wb expected wren=%0b waddr=%0d wdata=%h", test,
               exp.wren, exp.waddr, exp.wdata,
               " actual wren=%0b waddr=%0d wdata=%h", act.wren, act.waddr, act.wdata);
    end
  endtask

  task automatic check_trap(string test, trap_t exp, trap_t act);
    if (act.exception !== exp.exception ||
        (exp.exception && (act.ecause !== exp.ecause || act.epc !== exp.epc ||
                           act.etval !== exp.etval))) begin
      trap_errors++;
      $display("ERR %s trap expected exc=%0b cause=%0d epc=%h etval=%h", test,
               exp.exception, exp.ecause, exp.epc, exp.etval,
               " actual exc=%0b cause=%0d epc=%h etval=%h", act.exception,
               act.ecause, act.epc, act.etval);
    end
  endtask

  task automatic check_latency(string test, int exp, int act);
    if (act != exp) begin
      other_errors++;
      $display("ERR %s latency expected %0d actual %0d", test, exp, act);
    end
  endtask

  // ####################
  // Stimulus
  // ####################

  task automatic load_patterns(output logic ok);
    int       fd;
    int       c;
    int       cls;
    int       op;
    int       waddr;
    int       flags;
    int       fl;
    int       got;
    xlen_t    r1;
    xlen_t    r2;
    xlen_t    imm;
    xlen_t    pc;
    xlen_t    instr;
    xlen_t    expected;
    string    name;
    string    kind;
    pattern_t p;
    fd = $fopen("dv/execute_patterns.txt", "r");
    ok = (fd != 0);
    while (fd != 0 && $fscanf(fd, "%s", name) == 1) begin
      if (name.substr(0, 0) == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else begin
        got = $fscanf(fd, "%d %d %h %h %h %h %h %d %h %d %s %h", cls, op, r1, r2,
                      imm, pc, instr, waddr, flags, fl, kind, expected);
        if (got != 12) begin
          other_errors++;
          $display("Pattern %s has %0d of 12 fields", name, got);
        end
        p                = '0;
        p.issue.op_class = op_class_t'(cls);
        p.issue.alu_op   = alu_op_t'(op);
        p.issue.mul_op   = mul_op_t'(op % 4);
        p.issue.div_op   = div_op_t'(op % 4);
        p.issue.rdata1   = r1;
        p.issue.rdata2   = r2;
        p.issue.imm      = imm;
        p.issue.pc       = pc;
        p.issue.instr    = instr;
        p.issue.waddr    = reg_addr_t'(waddr);
        p.issue.sel_imm  = flags[0];
        p.issue.ecall    = flags[1];
        p.issue.ebreak   = flags[2];
        p.issue.illegal  = flags[3];
        p.flush          = fl[0];
        p.expected       = expected;
        patterns.push_back(p);
        names.push_back(name);
        kinds.push_back(kind);
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  // Flush drops a running divide.
  task automatic flush_test(string name);
    int n;
    if (!stall) begin
      other_errors++;
      $display("%s: stall low while the divide runs", name);
    end
    repeat (4) @(negedge clock);
    flush = 1'b1;
    #25;
    if (stall || retired || wb.wren) begin
      other_errors++;
      $display("%s: flush left stall or write-back active", name);
    end
    @(negedge clock);
    flush = 1'b0;
    for (n = 0; n < div_cycles + 4; n++) begin
      if (stall || retired || wb.wren) begin
        other_errors++;
        $display("%s: activity %0d cycles after flush", name, n);
      end
      @(negedge clock);
    end
  endtask

  task automatic run_test(string name, string kind, pattern_t p);
    int         waited;
    writeback_t wb_exp;
    trap_t      trap_exp;
    @(negedge clock);
    issue       = p.issue;
    issue.valid = 1'b1;
    @(negedge clock);
    issue  = '0;
    waited = 1;
    if (p.flush) begin
      flush_test(name);
    end else begin
      while (!(retired || trap.exception) && waited < unit_wait) begin
        if (!stall) begin
          other_errors++;
          $display("%s: stall low before the result, cycle %0d", name, waited);
        end
        @(negedge clock);
        waited++;
      end
      if (!(retired || trap.exception)) begin
        other_errors++;
        $display("%s: no retire or trap within %0d cycles", name, unit_wait);
      end else begin
        check_latency(name, expected_latency(p.issue.op_class), waited);
        trap_exp = '0;
        wb_exp   = '0;
        if (kind == "trap") begin
          trap_exp.exception = 1'b1;
          trap_exp.ecause    = ecause_t'(p.expected);
          trap_exp.epc       = p.issue.pc;
          trap_exp.etval     = p.issue.instr;
          check_wb(name, wb_exp, wb, 1'b0);
        end else begin
          wb_exp.wren  = (p.issue.waddr != '0);
          wb_exp.waddr = p.issue.waddr;
          wb_exp.wdata = p.expected;
          check_wb(name, wb_exp, wb, 1'b1);
        end
        check_trap(name, trap_exp, trap);
      end
    end
  endtask

  initial begin
    logic     ok;
    int       i;
    pattern_t p;
    void'($urandom(67));
    issue = '0;
    flush = 1'b0;
    reset = 1'b1;
    load_patterns(ok);
    if (!ok) begin
      other_errors++;
      $display("Pattern file dv/execute_patterns.txt could not be opened");
    end else begin
      cycle_limit = (patterns.size() + random_tests) * (div_cycles + 8) + reset_cycles;
      repeat (reset_cycles) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      for (i = 0; i < patterns.size(); i++) begin
        run_test(names[i], kinds[i], patterns[i]);
      end
      for (i = 0; i < random_tests; i++) begin
        p              = '0;
        p.issue.rdata1 = $urandom;
        p.issue.rdata2 = $urandom >> ($urandom % 32);  // Spread divisor sizes.
        p.issue.waddr  = reg_addr_t'(1 + i % 31);
        p.issue.pc     = 32'h0000_1000 + 4 * i;
        if (i % 2 == 0) begin
          p.issue.op_class = class_mul;
          p.issue.mul_op   = mul_op_t'((i / 2) % 4);
          p.expected       = mul_expected(p.issue.mul_op, p.issue.rdata1, p.issue.rdata2);
          run_test($sformatf("rand_mul_%0d", i), "wb", p);
        end else begin
          p.issue.op_class = class_div;
          p.issue.div_op   = div_op_t'((i / 2) % 4);
          p.expected       = div_expected(p.issue.div_op, p.issue.rdata1, p.issue.rdata2);
          run_test($sformatf("rand_div_%0d", i), "wb", p);
        end
      end
      repeat (2) @(negedge clock);
    end
    $display("Errors: wb %0d, trap %0d, other %0d", wb_errors, trap_errors, other_errors);
    if (wb_errors + trap_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- dv/execute_patterns.txt
# name class op rdata1 rdata2 imm pc instr waddr flags flush kind expected
# class 0 alu 1 lui 2 auipc 3 jump 4 mul 5 div 6 system, flags 1 imm 2 ecall 4 ebreak 8 illegal
add_reg 0 0 00000005 00000007 00000000 00000100 00728333 6 0 0 wb 0000000c
sub_reg 0 1 00000005 00000007 00000000 00000104 407283b3 7 0 0 wb fffffffe
addi_wrap 0 0 00000010 00000000 fffffff0 00000108 ff028413 8 1 0 wb 00000000
slt_neg 0 3 ffffffff 00000001 00000000 0000010c 0072a4b3 9 0 0 wb 00000001
sltiu_big 0 4 ffffffff 00000000 00000001 00000110 0012b513 10 1 0 wb 00000000
slli_low5 0 2 00000001 00000000 00000023 00000114 00329593 11 1 0 wb 00000008
srl_reg 0 6 80000000 00000004 00000000 00000118 0072d633 12 0 0 wb 08000000
sra_reg 0 7 80000000 00000004 00000000 0000011c 4072d6b3 13 0 0 wb f8000000
or_reg 0 8 0000f0f0 00000f0f 00000000 00000120 0072e733 14 0 0 wb 0000ffff
andi_mask 0 9 12345678 00000000 0000ff00 00000124 f002f793 15 1 0 wb 00005600
xor_x0 0 5 0000ff00 00ff0000 00000000 00000128 0072c033 0 0 0 wb 00ffff00
lui 1 0 00000000 00000000 12345000 00000000 12345837 16 0 0 wb 12345000
auipc 2 0 00000000 00000000 00001000 00000200 00001897 17 0 0 wb 00001200
jal 3 0 00000000 00000000 00000040 00000300 0400096f 18 0 0 wb 00000304
mul_edge 4 0 7fffffff 00000002 00000000 00000310 027289b3 19 0 0 wb fffffffe
mulh_min 4 1 80000000 80000000 00000000 00000314 02729a33 20 0 0 wb 40000000
mulhsu_neg 4 2 ffffffff ffffffff 00000000 00000318 0272aab3 21 0 0 wb ffffffff
mulhu_max 4 3 ffffffff ffffffff 00000000 0000031c 0272bb33 22 0 0 wb fffffffe
div_neg 5 0 fffffff9 00000002 00000000 00000320 0272cbb3 23 0 0 wb fffffffd
rem_neg 5 2 fffffff9 00000002 00000000 00000324 0272ec33 24 0 0 wb ffffffff
divu_basic 5 1 00000064 00000007 00000000 00000328 0272dcb3 25 0 0 wb 0000000e
remu_basic 5 3 00000064 00000007 00000000 0000032c 0272fd33 26 0 0 wb 00000002
div_zero 5 0 00000011 00000000 00000000 00000330 0202cdb3 27 0 0 wb ffffffff
remu_zero 5 3 00000011 00000000 00000000 00000334 0202fe33 28 0 0 wb 00000011
div_ovf 5 0 80000000 ffffffff 00000000 00000338 0272ceb3 29 0 0 wb 80000000
rem_ovf 5 2 80000000 ffffffff 00000000 0000033c 0272ef33 30 0 0 wb 00000000
illegal 6 0 00000000 00000000 00000000 00000400 ffffffff 1 8 0 trap 00000002
ebreak 6 0 00000000 00000000 00000000 00000404 00100073 1 4 0 trap 00000003
ecall 6 0 00000000 00000000 00000000 00000408 00000073 1 2 0 trap 0000000b
flush_div 5 1 00001000 00000003 00000000 00000500 0272d2b3 5 0 1 none 00000000
add_after_flush 0 0 00000003 00000004 00000000 00000504 00728333 6 0 0 wb 00000007

//--- all.f
hw/rv_types_pkg.sv
hw/execute_pkg.sv
hw/alu.sv
hw/multiplier.sv
hw/divider.sv
hw/execute_stage.sv
hw/execute_top.sv
dv/tb_execute.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - files:
      - hw/rv_types_pkg.sv
      - hw/execute_pkg.sv
      - hw/alu.sv
      - hw/multiplier.sv
      - hw/divider.sv
      - hw/execute_stage.sv
      - hw/execute_top.sv
  - target: test
    files:
      - dv/tb_execute.sv
